/* tag_dir_pkg.sv */
package tag_dir_pkg;

    localparam int NUM_LINES = 4;
    localparam int TAG_W     = $clog2(NUM_LINES);
    localparam int INDEX_W   = 8;
    localparam int NUM_PORTS = 3;

    typedef enum logic [2:0] {
        OP_LOOKUP = 3'd0,
        OP_ALLOC  = 3'd1,
        OP_FILL   = 3'd2,
        OP_WRITE  = 3'd3,
        OP_INVAL  = 3'd4
    } dir_op_e;

    typedef enum logic [1:0] {
        ST_INVALID = 2'd0,
        ST_FILLING = 2'd1,
        ST_VALID   = 2'd2,
        ST_DIRTY   = 2'd3
    } line_state_e;

    // pads the request out to 16 bits
    typedef struct packed {
        logic [1:0]         rsvd;
        logic               valid;
        dir_op_e            op;
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
    } dir_req_t;

    typedef struct packed {
        logic               valid;
        logic               accepted;
        logic               ok;
        logic               hit;
        logic [TAG_W-1:0]   tag;
        line_state_e        state;
        logic [INDEX_W-1:0] index;
    } dir_rsp_t;

endpackage

/* lru_order.sv */
`timescale 1ns/1ps

module lru_order (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          touch,
    input  logic [tag_dir_pkg::TAG_W-1:0] touch_tag,
    output logic [tag_dir_pkg::TAG_W-1:0] victim_tag
);
    import tag_dir_pkg::*;

    logic [TAG_W-1:0] prev_q [NUM_LINES];
    logic [TAG_W-1:0] next_q [NUM_LINES];
    logic [TAG_W-1:0] head_q;
    logic [TAG_W-1:0] tail_q;
    logic             at_head;
    logic             at_tail;

    assign at_head    = touch_tag == head_q;
    assign at_tail    = touch_tag == tail_q;
    assign victim_tag = tail_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // line 0 most recent, last line least recent
            for (int i = 0; i < NUM_LINES; i++) begin
                prev_q[i] <= TAG_W'(i - 1);
                next_q[i] <= TAG_W'(i + 1);
            end
            head_q <= '0;
            tail_q <= TAG_W'(NUM_LINES - 1);
        end else if (touch && !at_head) begin
            next_q[touch_tag] <= head_q;
            prev_q[head_q]    <= touch_tag;
            head_q            <= touch_tag;
            if (at_tail) begin
                tail_q <= prev_q[touch_tag];
            end else begin
                // unlink from the middle
                next_q[prev_q[touch_tag]] <= next_q[touch_tag];
                prev_q[next_q[touch_tag]] <= prev_q[touch_tag];
            end
        end
    end

endmodule

/* line_store.sv */
`timescale 1ns/1ps

module line_store (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [tag_dir_pkg::INDEX_W-1:0] search_index,
    input  logic [tag_dir_pkg::TAG_W-1:0]   sel_tag,
    input  logic                            wr_en,
    input  tag_dir_pkg::line_state_e        wr_state,
    input  logic [tag_dir_pkg::INDEX_W-1:0] wr_index,
    output logic                            match_hit,
    output logic [tag_dir_pkg::TAG_W-1:0]   match_tag,
    output tag_dir_pkg::line_state_e        line_state,
    output logic [tag_dir_pkg::INDEX_W-1:0] line_index
);
    import tag_dir_pkg::*;

    line_state_e        state_q [NUM_LINES];
    logic [INDEX_W-1:0] index_q [NUM_LINES];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                state_q[i] <= ST_INVALID;
                index_q[i] <= '0;
            end
        end else if (wr_en) begin
            state_q[sel_tag] <= wr_state;
            index_q[sel_tag] <= wr_index;
        end
    end

    // at most one live line holds an index, lowest tag wins anyway
    always_comb begin
        match_hit = 1'b0;
        match_tag = '0;
        for (int i = NUM_LINES - 1; i >= 0; i--) begin
            if (state_q[i] != ST_INVALID && index_q[i] == search_index) begin
                match_hit = 1'b1;
                match_tag = TAG_W'(i);
            end
        end
    end

    assign line_state = state_q[sel_tag];
    assign line_index = index_q[sel_tag];

endmodule

/* dir_engine.sv */
`timescale 1ns/1ps

module dir_engine (
    input  logic                                clk,
    input  logic                                rst_n,
    input  tag_dir_pkg::dir_req_t               grant_req,
    input  logic                                match_hit,
    input  logic [tag_dir_pkg::TAG_W-1:0]       match_tag,
    input  tag_dir_pkg::line_state_e            line_state,
    input  logic [tag_dir_pkg::INDEX_W-1:0]     line_index,
    output logic [tag_dir_pkg::TAG_W-1:0]       sel_tag,
    output logic                                wr_en,
    output tag_dir_pkg::line_state_e            wr_state,
    output logic [tag_dir_pkg::INDEX_W-1:0]     wr_index,
    input  logic [tag_dir_pkg::TAG_W-1:0]       victim_tag,
    output logic                                touch,
    output logic [tag_dir_pkg::TAG_W-1:0]       touch_tag,
    output tag_dir_pkg::dir_rsp_t               result
);
    import tag_dir_pkg::*;

    dir_rsp_t rsp_d;

    // target line of the granted op
    always_comb begin
        case (grant_req.op)
            OP_ALLOC:          sel_tag = match_hit ? match_tag : victim_tag;
            OP_FILL, OP_WRITE: sel_tag = grant_req.tag;
            default:           sel_tag = match_tag;
        endcase
    end

    assign touch_tag = sel_tag;

    always_comb begin
        rsp_d          = '0;
        rsp_d.valid    = 1'b1;
        rsp_d.accepted = 1'b1;
        wr_en          = 1'b0;
        wr_state       = line_state;
        wr_index       = line_index;
        touch          = 1'b0;
        case (grant_req.op)
            OP_LOOKUP, OP_ALLOC: begin
                if (match_hit) begin
                    rsp_d.ok    = 1'b1;
                    rsp_d.hit   = 1'b1;
                    rsp_d.tag   = sel_tag;
                    rsp_d.state = line_state;
                    rsp_d.index = line_index;
                    touch       = 1'b1;
                end else if (grant_req.op == OP_LOOKUP) begin
                    rsp_d.ok = 1'b1;
                end else begin
                    // miss, the victim reports its old contents for writeback
                    rsp_d.tag   = sel_tag;
                    rsp_d.state = line_state;
                    rsp_d.index = line_index;
                    if (line_state != ST_FILLING) begin
                        rsp_d.ok = 1'b1;
                        wr_en    = 1'b1;
                        wr_state = ST_FILLING;
                        wr_index = grant_req.index;
                        touch    = 1'b1;
                    end
                end
            end
            OP_FILL: begin
                rsp_d.tag   = sel_tag;
                rsp_d.state = line_state;
                rsp_d.index = line_index;
                if (line_state == ST_FILLING) begin
                    rsp_d.ok = 1'b1;
                    wr_en    = 1'b1;
                    wr_state = ST_VALID;
                end
            end
            OP_WRITE: begin
                rsp_d.tag   = sel_tag;
                rsp_d.state = line_state;
                rsp_d.index = line_index;
                if (line_state == ST_VALID || line_state == ST_DIRTY) begin
                    rsp_d.ok = 1'b1;
                    wr_en    = 1'b1;
                    wr_state = ST_DIRTY;
                    touch    = 1'b1;
                end
            end
            OP_INVAL: begin
                if (match_hit) begin
                    rsp_d.hit   = 1'b1;
                    rsp_d.tag   = sel_tag;
                    rsp_d.state = line_state;
                    rsp_d.index = line_index;
                    if (line_state != ST_FILLING) begin
                        rsp_d.ok = 1'b1;
                        wr_en    = 1'b1;
                        wr_state = ST_INVALID;
                        wr_index = '0;
                    end
                end else begin
                    rsp_d.ok = 1'b1;
                end
            end
            default: begin
                rsp_d.ok = 1'b0;
            end
        endcase
        // idle cycle, nothing may change
        if (!grant_req.valid) begin
            rsp_d = '0;
            wr_en = 1'b0;
            touch = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= rsp_d;
        end
    end

endmodule

/* port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  tag_dir_pkg::dir_req_t req_0,
    input  tag_dir_pkg::dir_req_t req_1,
    input  tag_dir_pkg::dir_req_t req_2,
    input  tag_dir_pkg::dir_rsp_t result,
    output tag_dir_pkg::dir_req_t grant_req,
    output tag_dir_pkg::dir_rsp_t rsp_0,
    output tag_dir_pkg::dir_rsp_t rsp_1,
    output tag_dir_pkg::dir_rsp_t rsp_2
);
    import tag_dir_pkg::*;

    localparam int PORT_W = $clog2(NUM_PORTS);

    logic [NUM_PORTS-1:0] strobe;
    logic [NUM_PORTS-1:0] lose;
    logic [PORT_W-1:0]    win_port;
    logic [NUM_PORTS-1:0] lose_q;
    logic [PORT_W-1:0]    win_port_q;
    logic                 win_valid_q;
    dir_rsp_t             reject;

    assign strobe = {req_2.valid, req_1.valid, req_0.valid};

    // snoop first, then core 0, then core 1
    always_comb begin
        win_port  = '0;
        grant_req = '0;
        if (req_2.valid) begin
            win_port  = PORT_W'(2);
            grant_req = req_2;
        end else if (req_0.valid) begin
            win_port  = PORT_W'(0);
            grant_req = req_0;
        end else if (req_1.valid) begin
            win_port  = PORT_W'(1);
            grant_req = req_1;
        end
        lose = strobe;
        if (|strobe) begin
            lose[win_port] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid_q <= 1'b0;
            win_port_q  <= '0;
            lose_q      <= '0;
        end else begin
            win_valid_q <= |strobe;
            win_port_q  <= win_port;
            lose_q      <= lose;
        end
    end

    always_comb begin
        reject       = '0;
        reject.valid = 1'b1;
    end

    // losers get a bare reject, the winner gets the engine result
    always_comb begin
        rsp_0 = lose_q[0] ? reject : '0;
        rsp_1 = lose_q[1] ? reject : '0;
        rsp_2 = lose_q[2] ? reject : '0;
        if (win_valid_q) begin
            case (win_port_q)
                PORT_W'(0): rsp_0 = result;
                PORT_W'(1): rsp_1 = result;
                default:    rsp_2 = result;
            endcase
        end
    end

endmodule

/* tag_dir_top.sv */
`timescale 1ns/1ps

module tag_dir_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  tag_dir_pkg::dir_req_t req_0,
    input  tag_dir_pkg::dir_req_t req_1,
    input  tag_dir_pkg::dir_req_t req_2,
    output tag_dir_pkg::dir_rsp_t rsp_0,
    output tag_dir_pkg::dir_rsp_t rsp_1,
    output tag_dir_pkg::dir_rsp_t rsp_2
);
    import tag_dir_pkg::*;

    dir_req_t           grant_req;
    dir_rsp_t           result;
    logic               match_hit;
    logic [TAG_W-1:0]   match_tag;
    line_state_e        line_state;
    logic [INDEX_W-1:0] line_index;
    logic [TAG_W-1:0]   sel_tag;
    logic               wr_en;
    line_state_e        wr_state;
    logic [INDEX_W-1:0] wr_index;
    logic [TAG_W-1:0]   victim_tag;
    logic               touch;
    logic [TAG_W-1:0]   touch_tag;

    port_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_0     (req_0),
        .req_1     (req_1),
        .req_2     (req_2),
        .result    (result),
        .grant_req (grant_req),
        .rsp_0     (rsp_0),
        .rsp_1     (rsp_1),
        .rsp_2     (rsp_2)
    );

    dir_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .grant_req  (grant_req),
        .match_hit  (match_hit),
        .match_tag  (match_tag),
        .line_state (line_state),
        .line_index (line_index),
        .sel_tag    (sel_tag),
        .wr_en      (wr_en),
        .wr_state   (wr_state),
        .wr_index   (wr_index),
        .victim_tag (victim_tag),
        .touch      (touch),
        .touch_tag  (touch_tag),
        .result     (result)
    );

    line_store u_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .search_index (grant_req.index),
        .sel_tag      (sel_tag),
        .wr_en        (wr_en),
        .wr_state     (wr_state),
        .wr_index     (wr_index),
        .match_hit    (match_hit),
        .match_tag    (match_tag),
        .line_state   (line_state),
        .line_index   (line_index)
    );

    lru_order u_lru (
        .clk        (clk),
        .rst_n      (rst_n),
        .touch      (touch),
        .touch_tag  (touch_tag),
        .victim_tag (victim_tag)
    );

endmodule

/* tb_tag_dir.sv */
`timescale 1ns/1ps

module tb_tag_dir;
    import tag_dir_pkg::*;

    localparam int FIELDS     = 18;
    localparam int MAX_VEC    = 64;
    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 8;

    logic        clk = 1'b0;
    logic        rst_n;
    dir_req_t    req [NUM_PORTS];
    dir_rsp_t    rsp [NUM_PORTS];
    logic [7:0]  stim_mem [FIELDS*MAX_VEC];
    int          num_vec;
    int          error_count;
    int          check_count;
    int unsigned lcg_state;

    tag_dir_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req_0 (req[0]),
        .req_1 (req[1]),
        .req_2 (req[2]),
        .rsp_0 (rsp[0]),
        .rsp_1 (rsp[1]),
        .rsp_2 (rsp[2])
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // fixed priority: snoop port, then core 0, then core 1
    function automatic int winner_of(input logic [NUM_PORTS-1:0] strobe);
        if (strobe[2]) return 2;
        if (strobe[0]) return 0;
        if (strobe[1]) return 1;
        return -1;
    endfunction

    function automatic dir_req_t make_req(input int base);
        dir_req_t r;
        r       = '0;
        r.valid = stim_mem[base][0];
        r.op    = dir_op_e'(stim_mem[base+1][2:0]);
        r.index = stim_mem[base+2];
        r.tag   = stim_mem[base+3][TAG_W-1:0];
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic drive_vector(input int k);
        int base;
        base = k * FIELDS;
        req[0] <= make_req(base);
        req[1] <= make_req(base + 4);
        req[2] <= make_req(base + 8);
    endtask

    task automatic check_vector(input int k);
        int                   base;
        int                   win;
        logic [NUM_PORTS-1:0] strobe;
        dir_rsp_t             reject;
        string                pname;
        base   = k * FIELDS;
        reject = '0;
        reject.valid = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            strobe[p] = stim_mem[base+4*p][0];
        end
        win = winner_of(strobe);
        for (int p = 0; p < NUM_PORTS; p++) begin
            pname = $sformatf("vec%0d rsp_%0d", k, p);
            if (p == win) begin
                check_value({pname, ".valid"}, 32'(rsp[p].valid), 32'd1);
                check_value({pname, ".accepted"}, 32'(rsp[p].accepted),
                            32'(stim_mem[base+12]));
                check_value({pname, ".ok"}, 32'(rsp[p].ok), 32'(stim_mem[base+13]));
                check_value({pname, ".hit"}, 32'(rsp[p].hit), 32'(stim_mem[base+14]));
                check_value({pname, ".tag"}, 32'(rsp[p].tag), 32'(stim_mem[base+15]));
                check_value({pname, ".state"}, 32'(rsp[p].state), 32'(stim_mem[base+16]));
                check_value({pname, ".index"}, 32'(rsp[p].index), 32'(stim_mem[base+17]));
            end else if (strobe[p]) begin
                check_value(pname, 32'(rsp[p]), 32'(reject));
            end else begin
                check_value({pname, ".valid"}, 32'(rsp[p].valid), 32'd0);
            end
        end
    endtask

    initial begin
        int next_vec;
        int issued;
        int pending;
        int gap;
        rst_n       = 1'b0;
        req[0]      = '0;
        req[1]      = '0;
        req[2]      = '0;
        error_count = 0;
        check_count = 0;
        num_vec     = 0;
        lcg_state   = 32'd52401;
        for (int i = 0; i < FIELDS * MAX_VEC; i++) begin
            stim_mem[i] = 8'hff;
        end
        $readmemh("tag_dir_stim.txt", stim_mem);
        while (num_vec < MAX_VEC && stim_mem[num_vec*FIELDS] != 8'hff) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            error_count++;
            $display("no stimulus vectors were read from the stim file");
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        next_vec = 0;
        pending  = -1;
        gap      = 0;
        while (next_vec < num_vec || pending >= 0) begin
            @(posedge clk);
            issued = -1;
            if (next_vec < num_vec && gap == 0) begin
                drive_vector(next_vec);
                issued = next_vec;
                next_vec++;
                // idle gap of zero to three cycles
                lcg_state = lcg_next(lcg_state);
                gap = int'((lcg_state >> 16) % 4);
            end else begin
                req[0] <= '0;
                req[1] <= '0;
                req[2] <= '0;
                if (gap > 0) begin
                    gap--;
                end
            end
            // responses change at the rising edge, sample away from it
            @(negedge clk);
            if (pending >= 0) begin
                check_vector(pending);
            end else begin
                for (int p = 0; p < NUM_PORTS; p++) begin
                    check_value($sformatf("idle rsp_%0d.valid", p), 32'(rsp[p].valid), 32'd0);
                end
            end
            pending = issued;
        end
        @(posedge clk);
        $display("vectors: %0d, checks: %0d, errors: %0d", num_vec, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // five cycles per vector covers the drive, the response and the longest gap
    initial begin
        wait (rst_n === 1'b1);
        #((num_vec * 5 + 4) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* tag_dir_stim.txt */
// port0 / port1 / port2 each: valid op index tag (op 0 lookup 1 alloc 2 fill 3 write 4 inval)
// then the winner: accepted ok hit tag state index (state 0 inv 1 filling 2 valid 3 dirty)
1 0 0a 0  0 0 00 0  0 0 00 0  1 1 0 0 0 00
1 1 0a 0  0 0 00 0  0 0 00 0  1 1 0 3 0 00
1 1 14 0  0 0 00 0  0 0 00 0  1 1 0 2 0 00
1 1 1e 0  0 0 00 0  0 0 00 0  1 1 0 1 0 00
1 1 28 0  0 0 00 0  0 0 00 0  1 1 0 0 0 00
1 1 32 0  0 0 00 0  0 0 00 0  1 0 0 3 1 0a
0 0 00 0  1 2 00 3  0 0 00 0  1 1 0 3 1 0a
0 0 00 0  1 2 00 3  0 0 00 0  1 0 0 3 2 0a
1 3 00 3  0 0 00 0  0 0 00 0  1 1 0 3 2 0a
1 2 00 2  0 0 00 0  0 0 00 0  1 1 0 2 1 14
1 2 00 1  0 0 00 0  0 0 00 0  1 1 0 1 1 1e
1 2 00 0  0 0 00 0  0 0 00 0  1 1 0 0 1 28
1 0 14 0  0 0 00 0  0 0 00 0  1 1 1 2 2 14
1 0 1e 0  0 0 00 0  0 0 00 0  1 1 1 1 2 1e
1 0 28 0  0 0 00 0  0 0 00 0  1 1 1 0 2 28
1 1 3c 0  0 0 00 0  0 0 00 0  1 1 0 3 3 0a
1 1 28 0  0 0 00 0  0 0 00 0  1 1 1 0 2 28
1 0 1e 0  1 0 14 0  1 4 14 0  1 1 1 2 2 14
1 0 1e 0  1 0 28 0  0 0 00 0  1 1 1 1 2 1e
0 0 00 0  1 0 14 0  0 0 00 0  1 1 0 0 0 00
0 0 00 0  0 0 00 0  1 4 3c 0  1 0 1 3 1 3c
0 0 00 0  0 0 00 0  1 4 77 0  1 1 0 0 0 00
1 3 00 3  0 0 00 0  0 0 00 0  1 0 0 3 1 3c
0 0 00 0  0 0 00 0  1 4 1e 0  1 1 1 1 2 1e
1 0 1e 0  0 0 00 0  0 0 00 0  1 1 0 0 0 00
0 0 00 0  1 1 99 0  0 0 00 0  1 1 0 2 0 00

/* tag_dir.f */
tag_dir_pkg.sv
lru_order.sv
line_store.sv
dir_engine.sv
port_arbiter.sv
tag_dir_top.sv
tb_tag_dir.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_tag_dir -f tag_dir.f -o tb_tag_dir &&
./obj_dir/tb_tag_dir | tee sim.log &&
grep -q "ALL TESTS PASSED" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
